// ==== design/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Datapath widths
`define EX_XLEN       32
`define EX_REG_IDX_W  5
`define EX_OP_W       5

// Iterations of the multiply/divide datapath, one per operand bit
`define EX_MD_ITERS   32

//////////////////////////////
// Integer ALU operations
`define EX_OP_ADD     5'd0
`define EX_OP_SUB     5'd1
`define EX_OP_AND     5'd2
`define EX_OP_OR      5'd3
`define EX_OP_XOR     5'd4
`define EX_OP_SLL     5'd5
`define EX_OP_SRL     5'd6
`define EX_OP_SRA     5'd7
`define EX_OP_SLT     5'd8
`define EX_OP_SLTU    5'd9
`define EX_OP_LUI     5'd10
`define EX_OP_AUIPC   5'd11

// Conditional branches
`define EX_OP_BEQ     5'd12
`define EX_OP_BNE     5'd13
`define EX_OP_BLT     5'd14
`define EX_OP_BGE     5'd15
`define EX_OP_BLTU    5'd16
`define EX_OP_BGEU    5'd17

// Jumps
`define EX_OP_JAL     5'd18
`define EX_OP_JALR    5'd19

// Iterative multiply/divide
`define EX_OP_MUL     5'd20
`define EX_OP_MULHU   5'd21
`define EX_OP_DIV     5'd22
`define EX_OP_DIVU    5'd23
`define EX_OP_REM     5'd24
`define EX_OP_REMU    5'd25

`endif

// ==== design/ex_pkg.sv ====
`include "ex_macros.svh"

package ex_pkg;

  //////////////////////////////
  // Base types

  // Data word
  typedef logic [`EX_XLEN-1:0] xlen_t;

  // Architectural register index
  typedef logic [`EX_REG_IDX_W-1:0] reg_idx_t;

  // Operation code, see EX_OP_* macros
  typedef logic [`EX_OP_W-1:0] op_t;

  //////////////////////////////
  // Stage interfaces

  // Decoded instruction from the decode stage
  typedef struct packed {
    op_t      op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
    xlen_t    pc;
    // Second operand from imm instead of rs2
    logic     use_imm;
    logic     regwrite;
    logic     memread;
    logic     memwrite;
  } ex_req_t;

  // Write-back bypass, the oldest in-flight result
  typedef struct packed {
    logic     regwrite;
    reg_idx_t rd;
    xlen_t    data;
  } wb_byp_t;

  // EX/MEM pipeline register
  typedef struct packed {
    xlen_t    result;
    xlen_t    store_data;
    xlen_t    br_target;
    reg_idx_t rd;
    logic     regwrite;
    logic     memread;
    logic     memwrite;
    logic     br_taken;
  } ex_mem_t;

  //////////////////////////////
  // Multiply/divide sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    FIX  = 2'd2
  } md_state_t;

endpackage

// ==== design/ex_forward.sv ====
`timescale 1ns/1ns

module ex_forward import ex_pkg::*; (
  input  ex_req_t  req,
  input  wb_byp_t  wb,
  input  reg_idx_t fwd_rd,
  input  logic     fwd_regwrite,
  input  xlen_t    fwd_data,
  output xlen_t    op_a,
  output xlen_t    op_b,
  output xlen_t    store_data
);

  xlen_t rs1_fwd;
  xlen_t rs2_fwd;

  // Newest matching producer wins
  // EX/MEM is younger than the write-back bypass
  function automatic xlen_t pick_operand(
    input reg_idx_t idx,
    input xlen_t    reg_val,
    input reg_idx_t exm_rd,
    input logic     exm_we,
    input xlen_t    exm_val,
    input wb_byp_t  byp
  );
    xlen_t val;
    val = reg_val;
    // x0 is hardwired, never take a forwarded value for it
    if (idx != '0)
    begin
      if (exm_we && (exm_rd == idx))
      begin
        val = exm_val;
      end
      else if (byp.regwrite && (byp.rd == idx))
      begin
        val = byp.data;
      end
    end
    return val;
  endfunction

  //////////////////////////////
  // Source operand selection

  always_comb
  begin
    rs1_fwd = pick_operand(req.rs1, req.rs1_data, fwd_rd, fwd_regwrite, fwd_data, wb);
    rs2_fwd = pick_operand(req.rs2, req.rs2_data, fwd_rd, fwd_regwrite, fwd_data, wb);
  end

  // First ALU operand is always rs1
  assign op_a = rs1_fwd;

  // Immediate forms replace rs2
  assign op_b = req.use_imm ? req.imm : rs2_fwd;

  // Store data keeps the forwarded rs2 even with an immediate address offset
  assign store_data = rs2_fwd;

endmodule

// ==== design/ex_alu.sv ====
`timescale 1ns/1ns

`include "ex_macros.svh"

module ex_alu import ex_pkg::*; (
  input  op_t   op,
  input  xlen_t op_a,
  input  xlen_t op_b,
  input  xlen_t pc,
  input  xlen_t imm,
  output xlen_t alu_res,
  output xlen_t br_target,
  output logic  br_taken
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               eq;
  logic               lt_s;
  logic               lt_u;
  xlen_t              link;
  xlen_t              jalr_sum;

  // Shift amount, low bits of the second operand only
  assign shamt = op_b[SHAMT_W-1:0];

  // Shared comparator for SLT* and branches
  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  // Return address for JAL/JALR
  assign link = pc + xlen_t'(4);

  //////////////////////////////
  // Jump and branch target

  assign jalr_sum = op_a + imm;

  // JALR clears bit 0, all others are pc relative
  assign br_target = (op == `EX_OP_JALR) ? {jalr_sum[`EX_XLEN-1:1], 1'b0} : pc + imm;

  //////////////////////////////
  // Result and branch decision

  always_comb
  begin
    alu_res  = '0;
    br_taken = 1'b0;
    case (op)
      `EX_OP_ADD:   alu_res = op_a + op_b;
      `EX_OP_SUB:   alu_res = op_a - op_b;
      `EX_OP_AND:   alu_res = op_a & op_b;
      `EX_OP_OR:    alu_res = op_a | op_b;
      `EX_OP_XOR:   alu_res = op_a ^ op_b;
      `EX_OP_SLL:   alu_res = op_a << shamt;
      `EX_OP_SRL:   alu_res = op_a >> shamt;
      `EX_OP_SRA:   alu_res = xlen_t'($signed(op_a) >>> shamt);
      `EX_OP_SLT:   alu_res = xlen_t'(lt_s);
      `EX_OP_SLTU:  alu_res = xlen_t'(lt_u);
      // Upper immediate already shifted by decode
      `EX_OP_LUI:   alu_res = op_b;
      `EX_OP_AUIPC: alu_res = pc + op_b;
      // Branches produce no register value
      `EX_OP_BEQ:   br_taken = eq;
      `EX_OP_BNE:   br_taken = !eq;
      `EX_OP_BLT:   br_taken = lt_s;
      `EX_OP_BGE:   br_taken = !lt_s;
      `EX_OP_BLTU:  br_taken = lt_u;
      `EX_OP_BGEU:  br_taken = !lt_u;
      // Jumps always redirect
      `EX_OP_JAL,
      `EX_OP_JALR:
      begin
        alu_res  = link;
        br_taken = 1'b1;
      end
      default:
      begin
        alu_res  = '0;
        br_taken = 1'b0;
      end
    endcase
  end

endmodule

// ==== design/ex_muldiv_ctrl.sv ====
`timescale 1ns/1ns

module ex_muldiv_ctrl import ex_pkg::*; (
  input  logic bus,
  input  logic arst_n,
  input  logic start,
  input  logic hold,
  input  logic last,
  output logic busy,
  output logic load,
  output logic step,
  output logic fix
);

  md_state_t state;
  md_state_t state_nxt;

  //////////////////////////////
  // Sequencer outputs

  // Operands captured on the accepting edge
  assign load = start && (state == IDLE);

  // One iteration per cycle while running, frozen by hold
  assign step = (state == RUN) && !hold;

  // Sign and corner-case correction, result taken on this edge
  assign fix  = (state == FIX) && !hold;

  assign busy = (state != IDLE);

  // Next state
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (load)
        begin
          state_nxt = RUN;
        end
      end
      RUN:
      begin
        // Final iteration done on this edge
        if (step && last)
        begin
          state_nxt = FIX;
        end
      end
      FIX:
      begin
        if (fix)
        begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  // The stage must stall while an operation is in flight
  a_start_only_idle: assert property (
    @(posedge bus) disable iff (!arst_n) start |-> (state == IDLE)
  );

endmodule

// ==== design/ex_iter_counter.sv ====
`timescale 1ns/1ns

`include "ex_macros.svh"

module ex_iter_counter (
  input  logic bus,
  input  logic arst_n,
  input  logic load,
  input  logic step,
  output logic last
);

  localparam int CNT_W = $clog2(`EX_MD_ITERS);

  logic [CNT_W-1:0] cnt;

  // Count of completed iterations
  always_ff @(posedge bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt <= '0;
    end
    else if (load)
    begin
      cnt <= '0;
    end
    else if (step)
    begin
      // Wraps back to zero after the final step
      cnt <= cnt + 1'b1;
    end
  end

  // Current step is the final one
  assign last = (cnt == CNT_W'(`EX_MD_ITERS - 1));

endmodule

// ==== design/ex_muldiv_datapath.sv ====
`timescale 1ns/1ns

`include "ex_macros.svh"

module ex_muldiv_datapath import ex_pkg::*; (
  input  logic  bus,
  input  logic  arst_n,
  input  op_t   op,
  input  xlen_t a,
  input  xlen_t b,
  input  logic  load,
  input  logic  step,
  input  logic  fix,
  output xlen_t res
);

  // Operation class at load time
  logic  is_div;
  logic  is_signed;
  logic  neg_a;
  logic  neg_b;
  xlen_t mag_a;
  xlen_t mag_b;

  // Latched operation info
  op_t   op_q;
  logic  div_q;
  logic  neg_a_q;
  logic  neg_b_q;
  logic  zero_q;
  logic  ovf_q;

  // Iteration registers
  // hi holds partial product or remainder, lo holds multiplier or quotient
  xlen_t hi_q;
  xlen_t lo_q;
  xlen_t mcand_q;

  logic [`EX_XLEN:0]   mul_sum;
  logic [`EX_XLEN:0]   trial;
  logic [`EX_XLEN+1:0] diff;
  xlen_t               quot;
  xlen_t               rem;
  xlen_t               sel;

  //////////////////////////////
  // Operand preparation

  assign is_div    = op inside {`EX_OP_DIV, `EX_OP_DIVU, `EX_OP_REM, `EX_OP_REMU};
  assign is_signed = (op == `EX_OP_DIV) || (op == `EX_OP_REM);
  assign neg_a     = is_signed && a[`EX_XLEN-1];
  assign neg_b     = is_signed && b[`EX_XLEN-1];
  assign mag_a     = neg_a ? -a : a;
  assign mag_b     = neg_b ? -b : b;

  always_ff @(posedge bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      op_q    <= '0;
      div_q   <= 1'b0;
      neg_a_q <= 1'b0;
      neg_b_q <= 1'b0;
      zero_q  <= 1'b0;
      ovf_q   <= 1'b0;
    end
    else if (load)
    begin
      op_q    <= op;
      div_q   <= is_div;
      neg_a_q <= neg_a;
      neg_b_q <= neg_b;
      zero_q  <= (b == '0);
      // Most negative dividend over minus one
      ovf_q   <= is_signed && (a == {1'b1, {(`EX_XLEN-1){1'b0}}}) && (b == '1);
    end
  end

  //////////////////////////////
  // One iteration

  // Shift-add, low bits of the multiplier decide the add
  assign mul_sum = {1'b0, hi_q} + (lo_q[0] ? {1'b0, mcand_q} : '0);

  // Restoring subtract, one dividend bit shifted in
  assign trial = {hi_q, lo_q[`EX_XLEN-1]};
  assign diff  = {1'b0, trial} - {2'b00, mcand_q};

  always_ff @(posedge bus)
  begin
    if (load)
    begin
      // Multiply runs unsigned, the low half is sign agnostic
      hi_q    <= '0;
      lo_q    <= is_div ? mag_a : b;
      mcand_q <= is_div ? mag_b : a;
    end
    else if (step)
    begin
      if (div_q)
      begin
        hi_q <= diff[`EX_XLEN+1] ? trial[`EX_XLEN-1:0] : diff[`EX_XLEN-1:0];
        lo_q <= {lo_q[`EX_XLEN-2:0], !diff[`EX_XLEN+1]};
      end
      else
      begin
        hi_q <= mul_sum[`EX_XLEN:1];
        lo_q <= {mul_sum[0], lo_q[`EX_XLEN-1:1]};
      end
    end
  end

  //////////////////////////////
  // Sign and corner-case fix-up

  always_comb
  begin
    quot = (neg_a_q ^ neg_b_q) ? -lo_q : lo_q;
    // Remainder takes the sign of the dividend
    // With a zero divisor this already equals the dividend
    rem  = neg_a_q ? -hi_q : hi_q;
    if (zero_q)
    begin
      quot = '1;
    end
    else if (ovf_q)
    begin
      quot = {1'b1, {(`EX_XLEN-1){1'b0}}};
      rem  = '0;
    end
    case (op_q)
      `EX_OP_MUL:   sel = lo_q;
      `EX_OP_MULHU: sel = hi_q;
      `EX_OP_DIV,
      `EX_OP_DIVU:  sel = quot;
      default:      sel = rem;
    endcase
  end

  // Result presented only in the fix cycle
  assign res = fix ? sel : '0;

endmodule

// ==== design/ex_stage.sv ====
`timescale 1ns/1ns

`include "ex_macros.svh"

module ex_stage import ex_pkg::*; (
  input  logic    bus,
  input  logic    arst_n,
  input  logic    valid,
  input  ex_req_t req,
  input  wb_byp_t wb,
  input  logic    mem_hold,
  output ex_mem_t ex_mem,
  output logic    stall
);

  xlen_t    op_a;
  xlen_t    op_b;
  xlen_t    store_data;
  xlen_t    alu_res;
  xlen_t    br_target;
  logic     br_taken;
  xlen_t    md_res;
  logic     md_busy;
  logic     md_load;
  logic     md_step;
  logic     md_fix;
  logic     md_last;
  logic     md_start;
  logic     is_md;
  logic     is_branch;
  logic     alu_take;
  reg_idx_t md_rd;
  logic     md_regwrite;
  ex_mem_t  ex_mem_d;

  // Operation classes
  assign is_md     = req.op inside {`EX_OP_MUL, `EX_OP_MULHU, `EX_OP_DIV,
                                    `EX_OP_DIVU, `EX_OP_REM, `EX_OP_REMU};
  assign is_branch = req.op inside {`EX_OP_BEQ, `EX_OP_BNE, `EX_OP_BLT,
                                    `EX_OP_BGE, `EX_OP_BLTU, `EX_OP_BGEU};

  // Nothing consumed while stalled or held
  assign md_start = valid && is_md && !stall && !mem_hold;
  assign alu_take = valid && !is_md && !stall;

  assign stall = md_busy;

  //////////////////////////////
  // Datapath blocks

  ex_forward i_forward (
    .req          (req),
    .wb           (wb),
    .fwd_rd       (ex_mem.rd),
    .fwd_regwrite (ex_mem.regwrite),
    .fwd_data     (ex_mem.result),
    .op_a         (op_a),
    .op_b         (op_b),
    .store_data   (store_data)
  );

  ex_alu i_alu (
    .op        (req.op),
    .op_a      (op_a),
    .op_b      (op_b),
    .pc        (req.pc),
    .imm       (req.imm),
    .alu_res   (alu_res),
    .br_target (br_target),
    .br_taken  (br_taken)
  );

  ex_muldiv_ctrl i_md_ctrl (
    .bus    (bus),
    .arst_n (arst_n),
    .start  (md_start),
    .hold   (mem_hold),
    .last   (md_last),
    .busy   (md_busy),
    .load   (md_load),
    .step   (md_step),
    .fix    (md_fix)
  );

  ex_iter_counter i_md_cnt (
    .bus    (bus),
    .arst_n (arst_n),
    .load   (md_load),
    .step   (md_step),
    .last   (md_last)
  );

  ex_muldiv_datapath i_md_dp (
    .bus    (bus),
    .arst_n (arst_n),
    .op     (req.op),
    .a      (op_a),
    .b      (op_b),
    .load   (md_load),
    .step   (md_step),
    .fix    (md_fix),
    .res    (md_res)
  );

  // Destination of the operation in flight, upstream moves on after accept
  always_ff @(posedge bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      md_rd       <= '0;
      md_regwrite <= 1'b0;
    end
    else if (md_load)
    begin
      md_rd       <= req.rd;
      md_regwrite <= req.regwrite && (req.rd != '0);
    end
  end

  //////////////////////////////
  // EX/MEM register

  always_comb
  begin
    ex_mem_d            = '0;
    ex_mem_d.store_data = store_data;
    ex_mem_d.br_target  = br_target;
    ex_mem_d.memread    = alu_take && req.memread;
    ex_mem_d.memwrite   = alu_take && req.memwrite;
    ex_mem_d.br_taken   = alu_take && br_taken;
    if (md_fix)
    begin
      ex_mem_d.result   = md_res;
      ex_mem_d.rd       = md_rd;
      ex_mem_d.regwrite = md_regwrite;
    end
    else
    begin
      ex_mem_d.result   = alu_res;
      ex_mem_d.rd       = req.rd;
      // Branches, stores and x0 never write back
      ex_mem_d.regwrite = alu_take && req.regwrite && !is_branch &&
                          !req.memwrite && (req.rd != '0);
    end
  end

  always_ff @(posedge bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ex_mem <= '0;
    end
    else if (!mem_hold)
    begin
      ex_mem <= ex_mem_d;
    end
  end

  // Both the ALU path and the multiply/divide path must drop writes to x0
  a_no_x0_write: assert property (
    @(posedge bus) disable iff (!arst_n) $rose(ex_mem.regwrite) |-> (ex_mem.rd != '0)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 5
) (
  output logic bus,
  output logic arst_n
);

  // Free-running clock, starts low
  initial
  begin
    bus = 1'b0;
    forever
    begin
      #(PERIOD / 2) bus = ~bus;
    end
  end

  // Reset low for a fixed number of rising edges
  initial
  begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge bus);
    // Release away from the active edge
    @(negedge bus);
    arst_n = 1'b1;
  end

endmodule

// ==== verification/tb_ex_stage.sv ====
`timescale 1ns/1ns

`include "ex_macros.svh"

module tb_ex_stage import ex_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 5;
  localparam int MAX_VEC     = 64;
  localparam int CYC_PER_VEC = 40;
  localparam int MD_WAIT_MAX = 60;

  // One line of the vector file
  typedef struct packed {
    logic [8*12-1:0] name;
    ex_req_t         req;
    wb_byp_t         wb;
    // Issue right behind the previous vector
    logic            chain;
    xlen_t           exp_result;
    logic            exp_taken;
    xlen_t           exp_target;
    logic            exp_regwrite;
  } vec_t;

  logic        bus;
  logic        arst_n;
  logic        valid;
  ex_req_t     req;
  wb_byp_t     wb;
  logic        mem_hold;
  ex_mem_t     ex_mem;
  logic        stall;

  vec_t        vecs [MAX_VEC];
  int          n_vec;
  int          n_pass;
  int          n_fail;
  bit          test_ok;
  bit          pre_driven;
  int unsigned rnd_seed;

  tb_clock_gen #(
    .PERIOD     (CLK_PERIOD),
    .RST_CYCLES (RST_CYCLES)
  ) i_clk_gen (
    .bus    (bus),
    .arst_n (arst_n)
  );

  ex_stage i_dut (
    .bus      (bus),
    .arst_n   (arst_n),
    .valid    (valid),
    .req      (req),
    .wb       (wb),
    .mem_hold (mem_hold),
    .ex_mem   (ex_mem),
    .stall    (stall)
  );

  //////////////////////////////
  // Vector file and op classes

  task automatic read_vectors();
    int              fd;
    int              got;
    string           line;
    logic [8*12-1:0] name;
    logic [31:0]     fld [20];
    vec_t            v;
    n_vec = 0;
    fd = $fopen("verification/ex_input.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open verification/ex_input.txt");
      return;
    end
    while (!$feof(fd) && n_vec < MAX_VEC)
    begin
      line = "";
      got = $fgets(line, fd);
      // Comment and blank lines fail the full match
      got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                    fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15],
                    fld[16], fld[17], fld[18], fld[19]);
      if (got == 21)
      begin
        v                = '0;
        v.name           = name;
        v.req.op         = op_t'(fld[0]);
        v.req.rs1        = reg_idx_t'(fld[1]);
        v.req.rs2        = reg_idx_t'(fld[2]);
        v.req.rd         = reg_idx_t'(fld[3]);
        v.req.rs1_data   = fld[4];
        v.req.rs2_data   = fld[5];
        v.req.imm        = fld[6];
        v.req.pc         = fld[7];
        v.req.use_imm    = fld[8][0];
        v.req.regwrite   = fld[9][0];
        v.req.memread    = fld[10][0];
        v.req.memwrite   = fld[11][0];
        v.wb.regwrite    = fld[12][0];
        v.wb.rd          = reg_idx_t'(fld[13]);
        v.wb.data        = fld[14];
        v.chain          = fld[15][0];
        v.exp_result     = fld[16];
        v.exp_taken      = fld[17][0];
        v.exp_target     = fld[18];
        v.exp_regwrite   = fld[19][0];
        vecs[n_vec]      = v;
        n_vec++;
      end
    end
    $fclose(fd);
  endtask

  // Iterative ops, codes MUL to REMU
  function automatic bit is_md_op(input op_t op);
    return (op >= `EX_OP_MUL) && (op <= `EX_OP_REMU);
  endfunction

  // Branches and jumps carry a target
  function automatic bit is_ctrl_op(input op_t op);
    return (op >= `EX_OP_BEQ) && (op <= `EX_OP_JALR);
  endfunction

  // Store data is rs2 after forwarding
  // Previous chained result beats the bypass, x0 keeps its register value
  function automatic xlen_t expected_store_data(input int i);
    vec_t  v;
    xlen_t val;
    v   = vecs[i];
    val = v.req.rs2_data;
    if (v.req.rs2 != '0)
    begin
      if (v.chain && (i > 0) && vecs[i - 1].exp_regwrite &&
          (vecs[i - 1].req.rd == v.req.rs2))
      begin
        val = vecs[i - 1].exp_result;
      end
      else if (v.wb.regwrite && (v.wb.rd == v.req.rs2))
      begin
        val = v.wb.data;
      end
    end
    return val;
  endfunction

  //////////////////////////////
  // Drive, check, report

  task automatic drive_vector(input int i);
    valid    <= 1'b1;
    req      <= vecs[i].req;
    wb       <= vecs[i].wb;
    mem_hold <= 1'b0;
  endtask

  task automatic check_vector(input int i);
    vec_t  v;
    xlen_t exp_store;
    v = vecs[i];
    exp_store = expected_store_data(i);
    if (ex_mem.result !== v.exp_result)
    begin
      $display("CHECK FAILED %0s: ex_mem.result got %h expected %h",
               v.name, ex_mem.result, v.exp_result);
      test_ok = 1'b0;
    end
    if (ex_mem.regwrite !== v.exp_regwrite)
    begin
      $display("CHECK FAILED %0s: ex_mem.regwrite got %h expected %h",
               v.name, ex_mem.regwrite, v.exp_regwrite);
      test_ok = 1'b0;
    end
    if (v.exp_regwrite && (ex_mem.rd !== v.req.rd))
    begin
      $display("CHECK FAILED %0s: ex_mem.rd got %h expected %h", v.name, ex_mem.rd, v.req.rd);
      test_ok = 1'b0;
    end
    if (ex_mem.br_taken !== v.exp_taken)
    begin
      $display("CHECK FAILED %0s: ex_mem.br_taken got %h expected %h",
               v.name, ex_mem.br_taken, v.exp_taken);
      test_ok = 1'b0;
    end
    if (is_ctrl_op(v.req.op) && (ex_mem.br_target !== v.exp_target))
    begin
      $display("CHECK FAILED %0s: ex_mem.br_target got %h expected %h",
               v.name, ex_mem.br_target, v.exp_target);
      test_ok = 1'b0;
    end
    // Memory flags pass through with the instruction
    if (ex_mem.memread !== v.req.memread)
    begin
      $display("CHECK FAILED %0s: ex_mem.memread got %h expected %h",
               v.name, ex_mem.memread, v.req.memread);
      test_ok = 1'b0;
    end
    if (ex_mem.memwrite !== v.req.memwrite)
    begin
      $display("CHECK FAILED %0s: ex_mem.memwrite got %h expected %h",
               v.name, ex_mem.memwrite, v.req.memwrite);
      test_ok = 1'b0;
    end
    if (v.req.memwrite && (ex_mem.store_data !== exp_store))
    begin
      $display("CHECK FAILED %0s: ex_mem.store_data got %h expected %h",
               v.name, ex_mem.store_data, exp_store);
      test_ok = 1'b0;
    end
  endtask

  // Entered at a falling edge with mem_hold already sampled high
  task automatic hold_window(input int i, input int cycles, input logic stall_exp);
    ex_mem_t snap;
    snap = ex_mem;
    repeat (cycles)
    begin
      @(negedge bus);
      if (ex_mem !== snap)
      begin
        $display("CHECK FAILED %0s: ex_mem under mem_hold got %h expected %h",
                 vecs[i].name, ex_mem, snap);
        test_ok = 1'b0;
      end
      if (stall !== stall_exp)
      begin
        $display("CHECK FAILED %0s: stall under mem_hold got %h expected %h",
                 vecs[i].name, stall, stall_exp);
        test_ok = 1'b0;
      end
    end
    @(posedge bus);
    mem_hold <= 1'b0;
  endtask

  task automatic report_test(input logic [8*12-1:0] name);
    if (test_ok)
    begin
      n_pass++;
      $display("PASS %0s", name);
    end
    else
    begin
      n_fail++;
      $display("FAIL %0s", name);
    end
  endtask

  task automatic check_reset();
    test_ok = 1'b1;
    if (ex_mem !== '0)
    begin
      $display("CHECK FAILED reset: ex_mem got %h expected %h", ex_mem, ex_mem_t'(0));
      test_ok = 1'b0;
    end
    if (stall !== 1'b0)
    begin
      $display("CHECK FAILED reset: stall got %h expected 0", stall);
      test_ok = 1'b0;
    end
    report_test("reset");
  endtask

  //////////////////////////////
  // One vector from issue to check

  task automatic run_vector(input int i);
    int        waited;
    bit        do_hold;
    md_state_t st;
    test_ok = 1'b1;
    do_hold = 1'b0;
    if (!pre_driven)
    begin
      // At least one idle cycle so EX/MEM forwarding is off
      @(posedge bus);
      valid    <= 1'b0;
      mem_hold <= 1'b0;
      repeat ($urandom_range(2, 0)) @(posedge bus);
      @(posedge bus);
      drive_vector(i);
    end
    pre_driven = 1'b0;
    if (is_md_op(vecs[i].req.op))
    begin
      // Accepting edge, valid lasts one cycle
      @(posedge bus);
      valid <= 1'b0;
      @(negedge bus);
      if (stall !== 1'b1)
      begin
        $display("CHECK FAILED %0s: stall got %h expected 1", vecs[i].name, stall);
        test_ok = 1'b0;
      end
      // Freeze the unit part way through
      if ($urandom_range(1, 0) == 1)
      begin
        repeat ($urandom_range(16, 1)) @(posedge bus);
        mem_hold <= 1'b1;
        @(negedge bus);
        hold_window(i, $urandom_range(4, 1), 1'b1);
        @(negedge bus);
      end
      waited = 0;
      while ((stall === 1'b1) && (waited < MD_WAIT_MAX))
      begin
        @(negedge bus);
        waited++;
      end
      if (stall !== 1'b0)
      begin
        st = i_dut.i_md_ctrl.state;
        $display("%0s: stall still high after %0d cycles, sequencer in %s",
                 vecs[i].name, waited, st.name());
        test_ok = 1'b0;
      end
      else
      begin
        // Result lands on the edge where stall falls
        check_vector(i);
      end
    end
    else
    begin
      // Completion edge, next dependent vector goes out here
      @(posedge bus);
      if ((i + 1 < n_vec) && vecs[i + 1].chain)
      begin
        drive_vector(i + 1);
        pre_driven = 1'b1;
      end
      else
      begin
        valid    <= 1'b0;
        do_hold  = ($urandom_range(1, 0) == 1);
        mem_hold <= do_hold;
      end
      @(negedge bus);
      check_vector(i);
      if (do_hold)
      begin
        hold_window(i, $urandom_range(4, 1), 1'b0);
      end
    end
    report_test(vecs[i].name);
  endtask

  //////////////////////////////
  // Main sequence

  initial
  begin
    valid      = 1'b0;
    req        = '0;
    wb         = '0;
    mem_hold   = 1'b0;
    n_pass     = 0;
    n_fail     = 0;
    pre_driven = 1'b0;
    rnd_seed   = $urandom(63);
    read_vectors();
    if (n_vec == 0)
    begin
      $display("No test vectors were loaded");
      n_fail++;
    end
    wait (arst_n === 1'b1);
    @(negedge bus);
    check_reset();
    for (int i = 0; i < n_vec; i++)
    begin
      run_vector(i);
    end
    $display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog, budget scales with the vector count
  initial
  begin
    wait (n_vec > 0);
    #((n_vec * CYC_PER_VEC + RST_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with tests still running",
             n_vec * CYC_PER_VEC + RST_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== verification/ex_input.txt ====
# name op rs1 rs2 rd rs1_data rs2_data imm pc use_imm regwrite memread memwrite
# wb_we wb_rd wb_data chain exp_result exp_taken exp_target exp_regwrite, all hex
add_rr 00 01 02 03 00000005 00000007 00000000 00001000 0 1 0 0 0 00 00000000 0 0000000c 0 00000000 1
sub_fwd 01 03 02 04 00000000 00000007 00000000 00001004 0 1 0 0 1 03 00000099 1 00000005 0 00000000 1
x0_nofwd 00 00 04 05 00000000 00000000 00000000 00001008 0 1 0 0 1 00 12345678 1 00000005 0 00000000 1
byp_only 03 06 07 08 0000f000 00000000 00000000 0000100c 0 1 0 0 1 07 0000000f 0 0000f00f 0 00000000 1
and_imm 02 01 00 02 ff00ff00 00000000 0f0f0f0f 00001010 1 1 0 0 0 00 00000000 0 0f000f00 0 00000000 1
xor_rr 04 01 02 03 aaaa5555 ffff0000 00000000 00001014 0 1 0 0 0 00 00000000 0 55555555 0 00000000 1
sll_imm 05 01 00 03 00000001 00000000 0000001f 00001018 1 1 0 0 0 00 00000000 0 80000000 0 00000000 1
srl_rr 06 01 02 03 80000000 00000024 00000000 0000101c 0 1 0 0 0 00 00000000 0 08000000 0 00000000 1
sra_imm 07 01 00 03 80000000 00000000 00000004 00001020 1 1 0 0 0 00 00000000 0 f8000000 0 00000000 1
slt_rr 08 01 02 03 ffffffff 00000001 00000000 00001024 0 1 0 0 0 00 00000000 0 00000001 0 00000000 1
sltu_rr 09 01 02 03 ffffffff 00000001 00000000 00001028 0 1 0 0 0 00 00000000 0 00000000 0 00000000 1
lui 0a 00 00 06 00000000 00000000 12345000 0000102c 1 1 0 0 0 00 00000000 0 12345000 0 00000000 1
auipc 0b 00 00 06 00000000 00000000 00001000 00002000 1 1 0 0 0 00 00000000 0 00003000 0 00000000 1
store_sw 00 01 02 07 00000100 deadbeef 00000008 00002004 1 1 0 1 0 00 00000000 0 00000108 0 00000000 0
beq_t 0c 01 02 05 00000005 00000005 00000010 00001000 0 1 0 0 0 00 00000000 0 00000000 1 00001010 0
bne_nt 0d 01 02 05 00000005 00000005 fffffff0 00001000 0 0 0 0 0 00 00000000 0 00000000 0 00000ff0 0
blt_t 0e 01 02 00 fffffffe 00000001 00000020 00002000 0 0 0 0 0 00 00000000 0 00000000 1 00002020 0
bge_nt 0f 01 02 00 fffffffe 00000001 00000020 00002000 0 0 0 0 0 00 00000000 0 00000000 0 00002020 0
bltu_nt 10 01 02 00 fffffffe 00000001 00000020 00002000 0 0 0 0 0 00 00000000 0 00000000 0 00002020 0
bgeu_t 11 01 02 00 fffffffe 00000001 00000004 00003000 0 0 0 0 0 00 00000000 0 00000000 1 00003004 0
jal 12 00 00 01 00000000 00000000 00000100 00004000 1 1 0 0 0 00 00000000 0 00004004 1 00004100 1
jalr 13 02 00 01 00005003 00000000 00000010 00004000 1 1 0 0 0 00 00000000 0 00004004 1 00005012 1
mul_fwd 14 01 02 03 00000000 00000002 00000000 00004004 0 1 0 0 0 00 00000000 1 00008008 0 00000000 1
mul_neg 14 01 02 03 00000007 fffffffd 00000000 00005000 0 1 0 0 0 00 00000000 0 ffffffeb 0 00000000 1
mulhu 15 01 02 03 ffffffff ffffffff 00000000 00005000 0 1 0 0 0 00 00000000 0 fffffffe 0 00000000 1
div_neg 16 01 02 03 ffffffec 00000003 00000000 00005000 0 1 0 0 0 00 00000000 0 fffffffa 0 00000000 1
rem_neg 18 01 02 03 ffffffec 00000003 00000000 00005000 0 1 0 0 0 00 00000000 0 fffffffe 0 00000000 1
divu 17 01 02 03 00000064 00000007 00000000 00005000 0 1 0 0 0 00 00000000 0 0000000e 0 00000000 1
remu 19 01 02 03 00000064 00000007 00000000 00005000 0 1 0 0 0 00 00000000 0 00000002 0 00000000 1
div_zero 16 01 02 03 00000005 00000000 00000000 00005000 0 1 0 0 0 00 00000000 0 ffffffff 0 00000000 1
rem_zero 18 01 02 03 fffffff9 00000000 00000000 00005000 0 1 0 0 0 00 00000000 0 fffffff9 0 00000000 1
divu_zero 17 01 02 03 12345678 00000000 00000000 00005000 0 1 0 0 0 00 00000000 0 ffffffff 0 00000000 1
div_ovf 16 01 02 03 80000000 ffffffff 00000000 00005000 0 1 0 0 0 00 00000000 0 80000000 0 00000000 1
rem_ovf 18 01 02 03 80000000 ffffffff 00000000 00005000 0 1 0 0 0 00 00000000 0 00000000 0 00000000 1

// ==== compile.f ====
+incdir+design
design/ex_pkg.sv
design/ex_forward.sv
design/ex_alu.sv
design/ex_muldiv_ctrl.sv
design/ex_iter_counter.sv
design/ex_muldiv_datapath.sv
design/ex_stage.sv
verification/tb_clock_gen.sv
verification/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - include_dirs:
      - design
    files:
      - design/ex_pkg.sv
      - design/ex_forward.sv
      - design/ex_alu.sv
      - design/ex_muldiv_ctrl.sv
      - design/ex_iter_counter.sv
      - design/ex_muldiv_datapath.sv
      - design/ex_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_ex_stage.sv
